/* multiboot_pkg.sv */
package multiboot_pkg;

    // Packet slots in one boot request
    localparam int NUM_SLOTS = 10;
    localparam int SLOT_W = $clog2(NUM_SLOTS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);

    // Configuration packet words
    localparam logic [31:0] DUMMY_WORD       = 32'hFFFF_FFFF;
    localparam logic [31:0] SYNC_WORD        = 32'hAA99_5566;
    localparam logic [31:0] NOOP_WORD        = 32'h2000_0000;
    localparam logic [31:0] IDCODE_READ_HDR  = 32'h2801_8001;
    localparam logic [31:0] WBSTAR_WRITE_HDR = 32'h3002_0001;
    localparam logic [31:0] CMD_WRITE_HDR    = 32'h3000_8001;
    localparam logic [31:0] IPROG_CMD        = 32'h0000_000F;

    // Header type field of a type-1 packet
    localparam logic [2:0] TYPE1_HDR = 3'b001;

    // Device ID field inside the IDCODE word
    localparam int ID_FIELD_MSB = 20;
    localparam int ID_FIELD_LSB = 12;

    // Family whose flash wants the byte-doubled address
    localparam logic [8:0] DOUBLE_ADDR_ID = 9'h051;

    typedef enum logic [1:0] {
        KIND_IDLE    = 2'd0,
        KIND_WRITE   = 2'd1,
        KIND_ADDRESS = 2'd2
    } word_kind_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } op_t;

    typedef struct packed {
        logic [2:0]  hdr_type;
        op_t         opcode;
        logic [13:0] reg_addr;
        logic [1:0]  reserved;
        logic [10:0] word_count;
    } type1_hdr_t;

    // Same word seen as a type-1 header or as plain data
    typedef union packed {
        type1_hdr_t  hdr;
        logic [31:0] raw;
    } cfg_packet_t;

endpackage

/* cfg_word_if.sv */
interface cfg_word_if;

    // Handshake
    logic valid;
    logic ready;

    // Payload of one packet slot
    multiboot_pkg::cfg_packet_t word;
    multiboot_pkg::word_kind_t  kind;
    logic                       last;

    modport source (
        output valid,
        output word,
        output kind,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        input  kind,
        input  last,
        output ready
    );

endinterface

/* boot_sequencer.sv */
module boot_sequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic       boot_valid,
    output logic       boot_ready,
    input  logic       done,
    cfg_word_if.source words
);

    logic [multiboot_pkg::SLOT_W-1:0] slot;
    logic                             active;
    logic                             wait_done;
    logic                             accept;
    logic                             last_slot;
    logic                             xfer;
    multiboot_pkg::cfg_packet_t       slot_word;
    multiboot_pkg::word_kind_t        slot_kind;

    // Ready comes back together with the done pulse
    assign boot_ready = !active && (!wait_done || done);
    assign accept     = boot_valid && boot_ready;
    assign last_slot  = (slot == multiboot_pkg::LAST_SLOT);
    assign xfer       = words.valid && words.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            wait_done <= 1'b0;
            slot      <= '0;
        end else if (accept) begin
            active    <= 1'b1;
            wait_done <= 1'b0;
            slot      <= '0;
        end else if (xfer) begin
            if (last_slot) begin
                active    <= 1'b0;
                wait_done <= 1'b1;
            end else begin
                slot <= slot + 1'b1;
            end
        end else if (wait_done && done) begin
            wait_done <= 1'b0;
        end
    end

    // Packet table
    always_comb begin
        slot_kind = multiboot_pkg::KIND_WRITE;
        case (slot)
            4'd0: begin
                slot_word.raw = multiboot_pkg::DUMMY_WORD;
                slot_kind     = multiboot_pkg::KIND_IDLE;
            end
            4'd1: slot_word.raw = multiboot_pkg::SYNC_WORD;
            4'd3: slot_word.raw = multiboot_pkg::IDCODE_READ_HDR;
            4'd5: slot_word.raw = multiboot_pkg::WBSTAR_WRITE_HDR;
            4'd6: begin
                // Filled in by the driver from the resolver
                slot_word.raw = '0;
                slot_kind     = multiboot_pkg::KIND_ADDRESS;
            end
            4'd7: slot_word.raw = multiboot_pkg::CMD_WRITE_HDR;
            4'd8: slot_word.raw = multiboot_pkg::IPROG_CMD;
            default: slot_word.raw = multiboot_pkg::NOOP_WORD;
        endcase
    end

    assign words.valid = active;
    assign words.word  = slot_word;
    assign words.kind  = slot_kind;
    assign words.last  = active && last_slot;

    // A stalled slot keeps its word until the driver takes it
    assert property (@(posedge clk) disable iff (reset)
        words.valid && !words.ready |=>
            words.valid && $stable(words.word) && $stable(words.kind));

    // No second request until the driver has finished the first
    assert property (@(posedge clk) disable iff (reset)
        accept |=> !boot_ready until done);

endmodule

/* boot_address_resolver.sv */
module boot_address_resolver (
    input  logic        clk,
    input  logic        reset,
    input  logic        boot_valid,
    input  logic        boot_ready,
    input  logic [31:0] boot_addr,
    input  logic [8:0]  id_code,
    input  logic        id_valid,
    output logic [31:0] wbstar_word,
    output logic        wbstar_valid
);

    logic [31:0] addr_q;
    logic [8:0]  id_q;
    logic        pending;
    logic        accept;
    logic        double_addr;

    // Same acceptance edge as the sequencer
    assign accept = boot_valid && boot_ready;

    // Byte-doubled address for the one family that needs it
    assign double_addr = (id_q == multiboot_pkg::DOUBLE_ADDR_ID);
    assign wbstar_word = double_addr ? {8'h00, addr_q[30:7]}
                                     : {8'h00, addr_q[31:8]};

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= boot_addr;
        end
        if (id_valid) begin
            id_q <= id_code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending      <= 1'b0;
            wbstar_valid <= 1'b0;
        end else if (accept) begin
            pending      <= 1'b1;
            wbstar_valid <= 1'b0;
        end else if (id_valid) begin
            pending      <= 1'b0;
            wbstar_valid <= 1'b1;
        end
    end

    // The driver reads the ID only inside an accepted request
    assert property (@(posedge clk) disable iff (reset)
        id_valid |-> pending);

endmodule

/* icap_driver.sv */
module icap_driver (
    input  logic        clk,
    input  logic        reset,
    cfg_word_if.sink    words,
    input  logic [31:0] wbstar_word,
    input  logic        wbstar_valid,
    output logic [8:0]  id_code,
    output logic        id_valid,
    output logic        done,
    output logic        icap_csib,
    output logic        icap_rdwrb,
    output logic [31:0] icap_i,
    input  logic [31:0] icap_o
);

    logic        xfer;
    logic        is_read_hdr;
    logic        addr_stall;
    logic        rd_noop;
    logic        rd_issue;
    logic        rd_wait;
    logic        read_seen;
    logic        stage_full;
    logic        stage_csib;
    logic        stage_rdwrb;
    logic        stage_last;
    logic [31:0] stage_word;
    logic        out_last;

    // The port expects each byte with its bit order flipped
    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            for (int k = 0; k < 8; k++) begin
                r[8*b + k] = w[8*b + 7 - k];
            end
        end
        return r;
    endfunction

    assign xfer = words.valid && words.ready;

    // Type-1 read header, the dummy and sync words do not count
    assign is_read_hdr = (words.kind == multiboot_pkg::KIND_WRITE)
        && (words.word.hdr.hdr_type == multiboot_pkg::TYPE1_HDR)
        && (words.word.hdr.opcode == multiboot_pkg::OP_READ);

    assign addr_stall  = (words.kind == multiboot_pkg::KIND_ADDRESS) && !wbstar_valid;
    assign words.ready = !rd_issue && !rd_wait && !addr_stall;

    // Read scheduling: one more word after the header, then the read slot
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_noop  <= 1'b0;
            rd_issue <= 1'b0;
            rd_wait  <= 1'b0;
        end else begin
            rd_issue <= xfer && rd_noop;
            if (xfer) begin
                rd_noop <= is_read_hdr && !rd_noop;
            end
            if (rd_issue) begin
                rd_wait <= 1'b1;
            end else if (icap_rdwrb) begin
                rd_wait <= 1'b0;
            end
        end
    end

    // Staging register
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_full  <= 1'b0;
            stage_csib  <= 1'b1;
            stage_rdwrb <= 1'b0;
            stage_last  <= 1'b0;
        end else if (xfer) begin
            stage_full  <= 1'b1;
            stage_csib  <= (words.kind == multiboot_pkg::KIND_IDLE);
            stage_rdwrb <= 1'b0;
            stage_last  <= words.last;
        end else if (rd_issue) begin
            stage_full  <= 1'b1;
            stage_csib  <= 1'b0;
            stage_rdwrb <= 1'b1;
            stage_last  <= 1'b0;
        end else begin
            // Bubble
            stage_full  <= 1'b0;
            stage_csib  <= 1'b1;
            stage_rdwrb <= 1'b0;
            stage_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            if (words.kind == multiboot_pkg::KIND_ADDRESS) begin
                stage_word <= wbstar_word;
            end else begin
                stage_word <= words.word.raw;
            end
        end else if (rd_issue) begin
            stage_word <= '0;
        end
    end

    // Output register facing the port
    always_ff @(posedge clk) begin
        if (reset) begin
            icap_i     <= '0;
            icap_csib  <= 1'b1;
            icap_rdwrb <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            if (stage_full) begin
                icap_i <= reverse_bytes(stage_word);
            end
            icap_csib  <= stage_csib;
            icap_rdwrb <= stage_rdwrb;
            out_last   <= stage_last;
        end
    end

    // ID is valid at the end of the read port cycle
    always_ff @(posedge clk) begin
        if (icap_rdwrb) begin
            id_code <= icap_o[multiboot_pkg::ID_FIELD_MSB:multiboot_pkg::ID_FIELD_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done      <= 1'b0;
            id_valid  <= 1'b0;
            read_seen <= 1'b0;
        end else begin
            done     <= out_last;
            id_valid <= icap_rdwrb;
            if (icap_rdwrb) begin
                read_seen <= 1'b1;
            end else if (done) begin
                read_seen <= 1'b0;
            end
        end
    end

    // Reads only happen with the port selected
    assert property (@(posedge clk) disable iff (reset)
        icap_rdwrb |-> !icap_csib);

    // Exactly one read cycle between two done pulses
    assert property (@(posedge clk) disable iff (reset)
        icap_rdwrb |-> !read_seen);
    assert property (@(posedge clk) disable iff (reset)
        done |-> read_seen);

endmodule

/* multiboot_top.sv */
module multiboot_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        boot_valid,
    output logic        boot_ready,
    input  logic [31:0] boot_addr,
    output logic        done,
    output logic [8:0]  id_code,
    output logic        icap_csib,
    output logic        icap_rdwrb,
    output logic [31:0] icap_i,
    input  logic [31:0] icap_o
);

    logic        id_valid;
    logic [31:0] wbstar_word;
    logic        wbstar_valid;

    // Packet stream from sequencer to driver
    cfg_word_if words_if ();

    boot_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .boot_valid (boot_valid),
        .boot_ready (boot_ready),
        .done       (done),
        .words      (words_if.source)
    );

    // Shares the request handshake with the sequencer
    boot_address_resolver u_resolver (
        .clk          (clk),
        .reset        (reset),
        .boot_valid   (boot_valid),
        .boot_ready   (boot_ready),
        .boot_addr    (boot_addr),
        .id_code      (id_code),
        .id_valid     (id_valid),
        .wbstar_word  (wbstar_word),
        .wbstar_valid (wbstar_valid)
    );

    icap_driver u_driver (
        .clk          (clk),
        .reset        (reset),
        .words        (words_if.sink),
        .wbstar_word  (wbstar_word),
        .wbstar_valid (wbstar_valid),
        .id_code      (id_code),
        .id_valid     (id_valid),
        .done         (done),
        .icap_csib    (icap_csib),
        .icap_rdwrb   (icap_rdwrb),
        .icap_i       (icap_i),
        .icap_o       (icap_o)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // Period of 20
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tb_multiboot.sv */
module tb_multiboot;

    localparam int MAX_REQ    = 16;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset;
    logic        boot_valid;
    logic        boot_ready;
    logic [31:0] boot_addr;
    logic        done;
    logic [8:0]  id_code;
    logic        icap_csib;
    logic        icap_rdwrb;
    logic [31:0] icap_i;
    logic [31:0] icap_o;

    // Four words per request: address, ID, WBSTAR payload, idle gap
    logic [31:0] stim [0:4*MAX_REQ-1];
    logic [31:0] written [$];
    logic [31:0] expected [0:8];
    logic [8:0]  cur_id;
    int          read_count;
    int          read_pos;
    int          done_count;
    int          errors;
    int          checks;
    bit          timed_out;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    multiboot_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .boot_valid (boot_valid),
        .boot_ready (boot_ready),
        .boot_addr  (boot_addr),
        .done       (done),
        .id_code    (id_code),
        .icap_csib  (icap_csib),
        .icap_rdwrb (icap_rdwrb),
        .icap_i     (icap_i),
        .icap_o     (icap_o)
    );

    // Bit i of a byte pairs with bit 7-i of the same byte
    function automatic logic [31:0] unreverse(input logic [31:0] w);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = w[i ^ 7];
        end
        return r;
    endfunction

    // ICAP model, ID field sits in bits 20 to 12
    assign icap_o = icap_rdwrb ? {11'b0, cur_id, 12'b0} : 32'h0;

    always @(posedge clk) begin
        if (!reset && !icap_csib) begin
            if (icap_rdwrb) begin
                read_count++;
                read_pos = written.size();
            end else begin
                written.push_back(unreverse(icap_i));
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && done) begin
            done_count++;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at time %0t", what, $time);
    endtask

    task automatic wait_for_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(negedge clk);
            ok = boot_ready;
        end
    endtask

    task automatic wait_for_done(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(negedge clk);
            if (done) begin
                ok = 1'b1;
            end else if (boot_ready) begin
                report_failure("boot_ready went high before done");
            end
        end
    endtask

    task automatic run_request(input int r, output bit ok);
        logic [31:0] addr;
        logic [31:0] exp_wbstar;
        logic [31:0] gap;
        logic [8:0]  id;
        addr       = stim[4*r];
        id         = stim[4*r+1][8:0];
        exp_wbstar = stim[4*r+2];
        gap        = stim[4*r+3];
        expected   = '{multiboot_pkg::SYNC_WORD, multiboot_pkg::NOOP_WORD,
                       multiboot_pkg::IDCODE_READ_HDR, multiboot_pkg::NOOP_WORD,
                       multiboot_pkg::WBSTAR_WRITE_HDR, exp_wbstar,
                       multiboot_pkg::CMD_WRITE_HDR, multiboot_pkg::IPROG_CMD,
                       multiboot_pkg::NOOP_WORD};
        repeat (gap) @(posedge clk);
        written.delete();
        read_count = 0;
        read_pos   = -1;
        cur_id     = id;
        @(posedge clk);
        boot_valid <= 1'b1;
        boot_addr  <= addr;
        wait_for_ready(ok);
        if (!ok) begin
            report_failure("Timeout while waiting for boot_ready");
            return;
        end
        // Acceptance edge, then boot_valid stays high a few more cycles
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (boot_ready) begin
                report_failure("boot_ready high while a request is running");
            end
        end
        @(posedge clk);
        boot_valid <= 1'b0;
        wait_for_done(ok);
        if (!ok) begin
            report_failure("Timeout while waiting for done");
            return;
        end
        checks++;
        if (!boot_ready) begin
            report_failure("boot_ready did not rise with done");
        end
        check_value("id_code", id_code, id);
        check_value("written word count", written.size(), 9);
        if (written.size() == 9) begin
            for (int i = 0; i < 9; i++) begin
                check_value($sformatf("written word %0d", i), written[i], expected[i]);
            end
        end
        check_value("read cycle count", read_count, 1);
        check_value("words written before read cycle", read_pos, 4);
    endtask

    initial begin
        int nreq;
        bit ok;
        boot_valid = 1'b0;
        boot_addr  = '0;
        cur_id     = '0;
        errors     = 0;
        checks     = 0;
        read_count = 0;
        read_pos   = -1;
        done_count = 0;
        timed_out  = 1'b0;
        $readmemh("multiboot_stimulus.txt", stim);
        nreq = 0;
        while (nreq < MAX_REQ && !$isunknown(stim[4*nreq])) begin
            nreq++;
        end
        if (nreq == 0) begin
            report_failure("No requests found in the stimulus file");
        end

        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(negedge clk);
            ok = !reset;
        end
        if (!ok) begin
            report_failure("Timeout while waiting for reset to end");
            timed_out = 1'b1;
        end else begin
            // Port idle before any request
            check_value("icap_csib after reset", icap_csib, 1);
            check_value("icap_rdwrb after reset", icap_rdwrb, 0);
            check_value("icap_i after reset", icap_i, 0);
            check_value("done after reset", done, 0);
            check_value("boot_ready after reset", boot_ready, 1);
        end

        for (int r = 0; r < nreq && !timed_out; r++) begin
            run_request(r, ok);
            timed_out = !ok;
        end

        if (!timed_out) begin
            repeat (3) @(negedge clk);
            check_value("done pulse count", done_count, nreq);
        end

        $display("Requests: %0d, checks: %0d, errors: %0d", nreq, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* multiboot_stimulus.txt */
// address  id  wbstar_payload  gap    (hex, one request per line)
// id 051 takes address bits 30:7, every other id takes bits 31:8
00400000 051 00008000 0
00400000 03A 00004000 3
81234500 051 0002468A 1
81234500 127 00812345 0
FFFFFF00 051 00FFFFFE 5
01234567 000 00012345 2
00ABCD80 051 0001579B 0

/* multiboot.f */
multiboot_pkg.sv
cfg_word_if.sv
boot_sequencer.sv
boot_address_resolver.sv
icap_driver.sv
multiboot_top.sv
tb_clock_gen.sv
tb_multiboot.sv

/* Bender.yml */
package:
  name: multiboot

sources:
  - multiboot_pkg.sv
  - cfg_word_if.sv
  - boot_sequencer.sv
  - boot_address_resolver.sv
  - icap_driver.sv
  - multiboot_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_multiboot.sv
